//--- rtl/rv_isa_pkg.sv
// RV32 base ISA definitions: opcodes, field widths, register numbers
// and the R/I/S/B/U/J instruction word builders
package rv_isa_pkg;

  localparam int unsigned ILEN  = 32;
  localparam int unsigned OPC_W = 7;
  localparam int unsigned REG_W = 5;
  localparam int unsigned F3_W  = 3;
  localparam int unsigned F7_W  = 7;

  typedef logic [ILEN-1:0] instr_t;

  // major opcodes used by the compressed expansion
  localparam logic [OPC_W-1:0] OPCODE_OP_IMM = 7'b0010011;
  localparam logic [OPC_W-1:0] OPCODE_OP     = 7'b0110011;
  localparam logic [OPC_W-1:0] OPCODE_LOAD   = 7'b0000011;
  localparam logic [OPC_W-1:0] OPCODE_STORE  = 7'b0100011;
  localparam logic [OPC_W-1:0] OPCODE_LUI    = 7'b0110111;
  localparam logic [OPC_W-1:0] OPCODE_JAL    = 7'b1101111;
  localparam logic [OPC_W-1:0] OPCODE_BRANCH = 7'b1100011;
  localparam logic [OPC_W-1:0] OPCODE_JALR   = 7'b1100111;

  localparam instr_t EBREAK_WORD = 32'h0010_0073;

  localparam logic [REG_W-1:0] REG_ZERO = 5'd0;
  localparam logic [REG_W-1:0] REG_RA   = 5'd1;
  localparam logic [REG_W-1:0] REG_SP   = 5'd2;

  //////////////////////////////
  // word builders
  //////////////////////////////

  function automatic instr_t build_r(input logic [F7_W-1:0] funct7, input logic [REG_W-1:0] rs2,
                                     input logic [REG_W-1:0] rs1, input logic [F3_W-1:0] funct3,
                                     input logic [REG_W-1:0] rd, input logic [OPC_W-1:0] opcode);
    return {funct7, rs2, rs1, funct3, rd, opcode};
  endfunction

  function automatic instr_t build_i(input logic [11:0] imm, input logic [REG_W-1:0] rs1,
                                     input logic [F3_W-1:0] funct3, input logic [REG_W-1:0] rd,
                                     input logic [OPC_W-1:0] opcode);
    return {imm, rs1, funct3, rd, opcode};
  endfunction

  // immediate split around the register fields
  function automatic instr_t build_s(input logic [11:0] imm, input logic [REG_W-1:0] rs2,
                                     input logic [REG_W-1:0] rs1, input logic [F3_W-1:0] funct3,
                                     input logic [OPC_W-1:0] opcode);
    return {imm[11:5], rs2, rs1, funct3, imm[4:0], opcode};
  endfunction

  function automatic instr_t build_b(input logic [12:0] imm, input logic [REG_W-1:0] rs2,
                                     input logic [REG_W-1:0] rs1, input logic [F3_W-1:0] funct3,
                                     input logic [OPC_W-1:0] opcode);
    return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], opcode};
  endfunction

  function automatic instr_t build_u(input logic [19:0] imm, input logic [REG_W-1:0] rd,
                                     input logic [OPC_W-1:0] opcode);
    return {imm, rd, opcode};
  endfunction

  function automatic instr_t build_j(input logic [20:0] imm, input logic [REG_W-1:0] rd,
                                     input logic [OPC_W-1:0] opcode);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opcode};
  endfunction

endpackage

//--- rtl/rvc_pkg.sv
// compressed parcel definitions: width, quadrant and funct3 codes,
// and the two-view parcel union
package rvc_pkg;

  localparam int unsigned PLEN = 16;

  localparam logic [1:0] QUAD_C0 = 2'b00;
  localparam logic [1:0] QUAD_C1 = 2'b01;
  localparam logic [1:0] QUAD_C2 = 2'b10;

  // quadrant 0
  localparam logic [2:0] C0_ADDI4SPN = 3'b000;
  localparam logic [2:0] C0_LW       = 3'b010;
  localparam logic [2:0] C0_ZCB      = 3'b100;
  localparam logic [2:0] C0_SW       = 3'b110;

  // quadrant 1
  localparam logic [2:0] C1_ADDI     = 3'b000;
  localparam logic [2:0] C1_JAL      = 3'b001;
  localparam logic [2:0] C1_LI       = 3'b010;
  localparam logic [2:0] C1_LUI      = 3'b011;
  localparam logic [2:0] C1_MISC_ALU = 3'b100;
  localparam logic [2:0] C1_J        = 3'b101;
  localparam logic [2:0] C1_BEQZ     = 3'b110;
  localparam logic [2:0] C1_BNEZ     = 3'b111;

  // quadrant 2
  localparam logic [2:0] C2_SLLI     = 3'b000;
  localparam logic [2:0] C2_LWSP     = 3'b010;
  localparam logic [2:0] C2_CR       = 3'b100;
  localparam logic [2:0] C2_SWSP     = 3'b110;

  // ci view carries full register numbers, cl view the 3-bit primed ones
  typedef union packed {
    struct packed {
      logic [2:0] funct3;
      logic       imm_hi;
      logic [4:0] rd;
      logic [4:0] imm_lo;
      logic [1:0] quad;
    } ci;
    struct packed {
      logic [2:0] funct3;
      logic [2:0] hi;
      logic [2:0] rs1p;
      logic [1:0] mid;
      logic [2:0] rdp;
      logic [1:0] quad;
    } cl;
  } parcel_t;

endpackage

//--- rtl/fetch_parcel_split.sv
// fetch block input register, one parcel and one valid per lane
`timescale 1ns/1ps

module fetch_parcel_split #(
  parameter int unsigned NUM_LANES = 2
) (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              fetch_valid_i,
  input  rvc_pkg::parcel_t [NUM_LANES-1:0]  fetch_block_i,
  input  logic [NUM_LANES-1:0]              lane_mask_i,
  output rvc_pkg::parcel_t [NUM_LANES-1:0]  parcel_o,
  output logic [NUM_LANES-1:0]              lane_valid_o
);

  // a lane is live only when the block is valid and its mask bit is set
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lane_valid_o <= '0;
    end else begin
      lane_valid_o <= lane_mask_i & {NUM_LANES{fetch_valid_i}};
    end
  end

  // parcels only load on a valid block
  always_ff @(posedge clk_i) begin
    if (fetch_valid_i) begin
      parcel_o <= fetch_block_i;
    end
  end

endmodule

//--- rtl/rvc_expand_lane.sv
// single lane RV32C expander: one parcel to one RV32 word and an illegal flag
`timescale 1ns/1ps

module rvc_expand_lane (
  input  rvc_pkg::parcel_t    parcel_i,
  output rv_isa_pkg::instr_t  instr_o,
  output logic                illegal_o
);
  import rv_isa_pkg::*;
  import rvc_pkg::*;

  logic [PLEN-1:0]  p;
  logic [REG_W-1:0] c_rd;
  logic [REG_W-1:0] c_rs2;
  logic [REG_W-1:0] c_rdp;
  logic [REG_W-1:0] c_rs1p;
  logic [11:0]      ci_imm;
  logic [11:0]      ciw_imm;
  logic [11:0]      lw_imm;
  logic [11:0]      lb_imm;
  logic [11:0]      lh_imm;
  logic [11:0]      lwsp_imm;
  logic [11:0]      swsp_imm;
  logic [11:0]      addi16sp_imm;
  logic [12:0]      cb_imm;
  logic [20:0]      cj_imm;
  instr_t           instr_d;
  logic             illegal_d;

  //////////////////////////////
  // fields and immediates
  //////////////////////////////
  assign p      = parcel_i;
  assign c_rd   = parcel_i.ci.rd;
  assign c_rs2  = parcel_i.ci.imm_lo;
  assign c_rdp  = {2'b01, parcel_i.cl.rdp};
  assign c_rs1p = {2'b01, parcel_i.cl.rs1p};

  assign ci_imm       = {{7{parcel_i.ci.imm_hi}}, parcel_i.ci.imm_lo};
  assign ciw_imm      = {2'b00, p[10:7], p[12:11], p[5], p[6], 2'b00};
  assign lw_imm       = {5'b00000, p[5], p[12:10], p[6], 2'b00};
  assign lb_imm       = {10'd0, p[5], p[6]};
  assign lh_imm       = {10'd0, p[5], 1'b0};
  assign lwsp_imm     = {4'b0000, p[3:2], p[12], p[6:4], 2'b00};
  assign swsp_imm     = {4'b0000, p[8:7], p[12:9], 2'b00};
  assign addi16sp_imm = {{3{p[12]}}, p[4:3], p[5], p[2], p[6], 4'b0000};
  assign cb_imm       = {{5{p[12]}}, p[6:5], p[2], p[11:10], p[4:3], 1'b0};
  assign cj_imm       = {{10{p[12]}}, p[8], p[10:9], p[6], p[7], p[2], p[11], p[5:3], 1'b0};

  //////////////////////////////
  // expansion
  //////////////////////////////
  always_comb begin
    instr_d   = '0;
    illegal_d = 1'b0;
    case (parcel_i.ci.quad)
      QUAD_C0: begin
        case (parcel_i.ci.funct3)
          C0_ADDI4SPN: begin
            instr_d   = build_i(ciw_imm, REG_SP, 3'b000, c_rdp, OPCODE_OP_IMM);
            illegal_d = (ciw_imm == '0);
          end
          C0_LW: instr_d = build_i(lw_imm, c_rs1p, 3'b010, c_rdp, OPCODE_LOAD);
          C0_ZCB: begin
            // only the Zcb loads survive, store slots fall to illegal
            case (parcel_i.cl.hi)
              3'b000: instr_d = build_i(lb_imm, c_rs1p, 3'b100, c_rdp, OPCODE_LOAD);
              3'b001: begin
                if (parcel_i.cl.mid[1]) begin
                  instr_d = build_i(lh_imm, c_rs1p, 3'b001, c_rdp, OPCODE_LOAD);
                end else begin
                  instr_d = build_i(lh_imm, c_rs1p, 3'b101, c_rdp, OPCODE_LOAD);
                end
              end
              default: illegal_d = 1'b1;
            endcase
          end
          C0_SW: instr_d = build_s(lw_imm, c_rdp, c_rs1p, 3'b010, OPCODE_STORE);
          default: illegal_d = 1'b1;
        endcase
      end
      QUAD_C1: begin
        case (parcel_i.ci.funct3)
          // rd of x0 gives c.nop
          C1_ADDI: instr_d = build_i(ci_imm, c_rd, 3'b000, c_rd, OPCODE_OP_IMM);
          C1_JAL:  instr_d = build_j(cj_imm, REG_RA, OPCODE_JAL);
          C1_LI:   instr_d = build_i(ci_imm, REG_ZERO, 3'b000, c_rd, OPCODE_OP_IMM);
          C1_LUI: begin
            if (c_rd == REG_SP) begin
              instr_d = build_i(addi16sp_imm, REG_SP, 3'b000, REG_SP, OPCODE_OP_IMM);
            end else begin
              instr_d = build_u({{8{ci_imm[11]}}, ci_imm}, c_rd, OPCODE_LUI);
            end
            illegal_d = (ci_imm == '0);
          end
          C1_MISC_ALU: begin
            case (parcel_i.cl.hi[1:0])
              2'b00: instr_d = build_i({7'b0000000, ci_imm[4:0]}, c_rs1p, 3'b101, c_rs1p,
                                       OPCODE_OP_IMM);
              2'b01: instr_d = build_i({7'b0100000, ci_imm[4:0]}, c_rs1p, 3'b101, c_rs1p,
                                       OPCODE_OP_IMM);
              2'b10: instr_d = build_i(ci_imm, c_rs1p, 3'b111, c_rs1p, OPCODE_OP_IMM);
              default: begin
                // register-register group, bit 12 and bits 6:5 pick the op
                case ({parcel_i.cl.hi[2], parcel_i.cl.mid})
                  3'b000: instr_d = build_r(7'b0100000, c_rdp, c_rs1p, 3'b000, c_rs1p, OPCODE_OP);
                  3'b001: instr_d = build_r(7'b0000000, c_rdp, c_rs1p, 3'b100, c_rs1p, OPCODE_OP);
                  3'b010: instr_d = build_r(7'b0000000, c_rdp, c_rs1p, 3'b110, c_rs1p, OPCODE_OP);
                  3'b011: instr_d = build_r(7'b0000000, c_rdp, c_rs1p, 3'b111, c_rs1p, OPCODE_OP);
                  3'b110: instr_d = build_r(7'b0000001, c_rdp, c_rs1p, 3'b000, c_rs1p, OPCODE_OP);
                  3'b111: begin
                    // Zcb unary ops, selected by the rd' field
                    case (parcel_i.cl.rdp)
                      3'b000: instr_d = build_i(12'h0ff, c_rs1p, 3'b111, c_rs1p, OPCODE_OP_IMM);
                      3'b001: instr_d = build_i(12'h604, c_rs1p, 3'b001, c_rs1p, OPCODE_OP_IMM);
                      3'b010: instr_d = build_r(7'b0000100, REG_ZERO, c_rs1p, 3'b100, c_rs1p,
                                                OPCODE_OP);
                      3'b011: instr_d = build_i(12'h605, c_rs1p, 3'b001, c_rs1p, OPCODE_OP_IMM);
                      3'b101: instr_d = build_i(12'hfff, c_rs1p, 3'b100, c_rs1p, OPCODE_OP_IMM);
                      default: illegal_d = 1'b1;
                    endcase
                  end
                  default: illegal_d = 1'b1;
                endcase
              end
            endcase
          end
          C1_J:    instr_d = build_j(cj_imm, REG_ZERO, OPCODE_JAL);
          C1_BEQZ: instr_d = build_b(cb_imm, REG_ZERO, c_rs1p, 3'b000, OPCODE_BRANCH);
          default: instr_d = build_b(cb_imm, REG_ZERO, c_rs1p, 3'b001, OPCODE_BRANCH);
        endcase
      end
      QUAD_C2: begin
        case (parcel_i.ci.funct3)
          C2_SLLI: instr_d = build_i({6'b000000, ci_imm[5:0]}, c_rd, 3'b001, c_rd, OPCODE_OP_IMM);
          C2_LWSP: begin
            instr_d   = build_i(lwsp_imm, REG_SP, 3'b010, c_rd, OPCODE_LOAD);
            illegal_d = (c_rd == REG_ZERO);
          end
          C2_CR: begin
            if (!parcel_i.ci.imm_hi) begin
              if (c_rs2 == REG_ZERO) begin
                // c.jr
                instr_d   = build_i(12'd0, c_rd, 3'b000, REG_ZERO, OPCODE_JALR);
                illegal_d = (c_rd == REG_ZERO);
              end else begin
                // c.mv
                instr_d = build_r(7'b0000000, c_rs2, REG_ZERO, 3'b000, c_rd, OPCODE_OP);
              end
            end else if (c_rs2 != REG_ZERO) begin
              // c.add
              instr_d = build_r(7'b0000000, c_rs2, c_rd, 3'b000, c_rd, OPCODE_OP);
            end else if (c_rd == REG_ZERO) begin
              instr_d = EBREAK_WORD;
            end else begin
              // c.jalr
              instr_d = build_i(12'd0, c_rd, 3'b000, REG_RA, OPCODE_JALR);
            end
          end
          C2_SWSP: instr_d = build_s(swsp_imm, c_rs2, REG_SP, 3'b010, OPCODE_STORE);
          default: illegal_d = 1'b1;
        endcase
      end
      // low bits 11 mark a full-width instruction, not a parcel
      default: illegal_d = 1'b1;
    endcase
  end

  assign instr_o   = illegal_d ? '0 : instr_d;
  assign illegal_o = illegal_d;

endmodule

//--- rtl/expand_result_reg.sv
// output register toward decode: expanded words, lane valids, illegal flags
`timescale 1ns/1ps

module expand_result_reg #(
  parameter int unsigned NUM_LANES = 2
) (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic [NUM_LANES-1:0]                lane_valid_i,
  input  rv_isa_pkg::instr_t [NUM_LANES-1:0]  instr_i,
  input  logic [NUM_LANES-1:0]                illegal_i,
  output logic [NUM_LANES-1:0]                instr_valid_o,
  output rv_isa_pkg::instr_t [NUM_LANES-1:0]  instr_block_o,
  output logic [NUM_LANES-1:0]                illegal_o
);

  // dead lanes never report illegal
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      instr_valid_o <= '0;
      illegal_o     <= '0;
    end else begin
      instr_valid_o <= lane_valid_i;
      illegal_o     <= illegal_i & lane_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    instr_block_o <= instr_i;
  end

endmodule

//--- rtl/rvc_expand_top.sv
// RV32C expansion stage: feeder register, NUM_LANES expanders, result register
`timescale 1ns/1ps

module rvc_expand_top #(
  parameter int unsigned NUM_LANES = 2
) (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic                                fetch_valid_i,
  input  rvc_pkg::parcel_t [NUM_LANES-1:0]    fetch_block_i,
  input  logic [NUM_LANES-1:0]                lane_mask_i,
  output logic [NUM_LANES-1:0]                instr_valid_o,
  output rv_isa_pkg::instr_t [NUM_LANES-1:0]  instr_block_o,
  output logic [NUM_LANES-1:0]                illegal_o
);
  import rv_isa_pkg::*;
  import rvc_pkg::*;

  parcel_t [NUM_LANES-1:0] parcel_q;
  logic [NUM_LANES-1:0]    lane_valid_q;
  instr_t [NUM_LANES-1:0]  lane_instr;
  logic [NUM_LANES-1:0]    lane_illegal;

  fetch_parcel_split #(.NUM_LANES(NUM_LANES)) fetch_parcel_split_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .fetch_valid_i(fetch_valid_i),
    .fetch_block_i(fetch_block_i),
    .lane_mask_i  (lane_mask_i),
    .parcel_o     (parcel_q),
    .lane_valid_o (lane_valid_q)
  );

  // one combinational expander per parcel slot
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    rvc_expand_lane rvc_expand_lane_inst (
      .parcel_i (parcel_q[g]),
      .instr_o  (lane_instr[g]),
      .illegal_o(lane_illegal[g])
    );
  end

  expand_result_reg #(.NUM_LANES(NUM_LANES)) expand_result_reg_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .lane_valid_i (lane_valid_q),
    .instr_i      (lane_instr),
    .illegal_i    (lane_illegal),
    .instr_valid_o(instr_valid_o),
    .instr_block_o(instr_block_o),
    .illegal_o    (illegal_o)
  );

endmodule

//--- testbench/rvc_expand_sva.sv
// output assertions for the expansion stage, bound to the top level
`timescale 1ns/1ps

module rvc_expand_sva #(
  parameter int unsigned NUM_LANES = 2
) (
  input logic                 clk_i,
  input logic                 rst_i,
  input logic [NUM_LANES-1:0] instr_valid_i,
  input logic [NUM_LANES-1:0] illegal_i,
  input logic [NUM_LANES-1:0] lane_valid_q_i
);

  // nothing leaves the stage while reset is held
  a_reset_quiet: assert property (@(posedge clk_i)
    rst_i |=> (instr_valid_i == '0 && illegal_i == '0))
    else $error("output valid or illegal flag during reset");

  a_illegal_on_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    (illegal_i & ~instr_valid_i) == '0)
    else $error("illegal flag raised on a lane that is not valid");

  // drainer adds exactly one register stage to the feeder valids
  a_valid_follows: assert property (@(posedge clk_i) disable iff (rst_i)
    instr_valid_i == $past(lane_valid_q_i))
    else $error("output valid does not follow the feeder valid");

endmodule

bind rvc_expand_top rvc_expand_sva #(.NUM_LANES(NUM_LANES)) rvc_expand_sva_inst (
  .clk_i         (clk_i),
  .rst_i         (rst_i),
  .instr_valid_i (instr_valid_o),
  .illegal_i     (illegal_o),
  .lane_valid_q_i(lane_valid_q)
);

//--- testbench/tb_rvc_expand.sv
// testbench for the RV32C expansion stage: directed forms, illegal slots,
// random back-to-back blocks and masked lanes against a reference expansion
`timescale 1ns/1ps

module tb_rvc_expand;
  import rv_isa_pkg::*;
  import rvc_pkg::*;

  localparam int NUM_LANES    = 2;
  localparam int RESET_CYCLES = 16;
  localparam int N_DIRECTED   = 48;
  localparam int N_RANDOM     = 2000;
  localparam int N_MIXED      = 100;
  localparam int CYCLE_LIMIT  = RESET_CYCLES + N_DIRECTED / NUM_LANES + N_RANDOM + N_MIXED + 50;

  logic                    clk = 1'b0;
  logic                    rst;
  logic                    fetch_valid;
  parcel_t [NUM_LANES-1:0] fetch_block;
  logic [NUM_LANES-1:0]    lane_mask;
  logic [NUM_LANES-1:0]    instr_valid;
  instr_t [NUM_LANES-1:0]  instr_block;
  logic [NUM_LANES-1:0]    illegal;
  string                   test_name;
  integer                  seed = 32'hd297_47d0;
  int                      cycles = 0;
  int                      sent_lanes = 0;
  int                      checked_lanes = 0;

  // one expected entry per cycle that is popped two cycles later
  logic [NUM_LANES-1:0]    exp_valid_q [$];
  parcel_t [NUM_LANES-1:0] exp_block_q [$];
  string                   exp_name_q [$];

  // kept forms first, then the illegal slots from entry 36 on
  logic [15:0] directed [N_DIRECTED] = '{
    16'b000_10110100_011_00, 16'b010_101_010_11_001_00, 16'b110_011_100_01_110_00,
    16'b100_000_101_10_010_00, 16'b100_001_011_01_100_00, 16'b100_001_011_11_100_00,
    16'b000_1_01010_11100_01, 16'b000_0_00000_00000_01, 16'b001_10110100101_01,
    16'b010_0_01111_10101_01, 16'b011_1_00010_01101_01, 16'b011_0_00101_10011_01,
    16'b100_0_00_011_00111_01, 16'b100_0_01_110_10100_01, 16'b100_1_10_001_11010_01,
    16'b100_0_11_010_00_101_01, 16'b100_0_11_011_01_110_01, 16'b100_0_11_100_10_111_01,
    16'b100_0_11_101_11_000_01, 16'b100_1_11_001_10_011_01, 16'b100_1_11_010_11_000_01,
    16'b100_1_11_010_11_001_01, 16'b100_1_11_010_11_010_01, 16'b100_1_11_010_11_011_01,
    16'b100_1_11_010_11_101_01, 16'b101_01101001110_01, 16'b110_101_011_10110_01,
    16'b111_010_110_01011_01, 16'b000_0_00110_00101_10, 16'b010_1_01001_01101_10,
    16'b100_0_00101_00000_10, 16'b100_0_01010_01011_10, 16'b100_1_00000_00000_10,
    16'b100_1_00111_00000_10, 16'b100_1_01000_10010_10, 16'b110_101101_01100_10,
    16'b000_00000000_101_00, 16'b011_0_00010_00000_01, 16'b011_0_00110_00000_01,
    16'b010_0_00000_00100_10, 16'b100_0_00000_00000_10, 16'b001_01010101_010_00,
    16'b100_1_11_011_00_010_01, 16'b100_1_11_011_11_110_01, 16'b011_0_00011_00100_10,
    16'b100_010_001_01_010_00, 16'b100_011_001_00_010_00, 16'h0513
  };

  rvc_expand_top #(.NUM_LANES(NUM_LANES)) rvc_expand_top_inst (
    .clk_i        (clk),
    .rst_i        (rst),
    .fetch_valid_i(fetch_valid),
    .fetch_block_i(fetch_block),
    .lane_mask_i  (lane_mask),
    .instr_valid_o(instr_valid),
    .instr_block_o(instr_block),
    .illegal_o    (illegal)
  );

  initial begin
    forever #2 clk = ~clk;
  end

  //////////////////////////////
  // reference expansion
  //////////////////////////////

  // returns {illegal, word}
  function automatic logic [32:0] ref_expand(input logic [15:0] c);
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  rdp;
    logic [4:0]  rs1p;
    logic [11:0] imm6;
    logic [11:0] imm;
    logic [20:0] joff;
    logic [12:0] boff;
    logic [31:0] w;
    logic        bad;
    rd   = c[11:7];
    rs2  = c[6:2];
    rdp  = {2'b01, c[4:2]};
    rs1p = {2'b01, c[9:7]};
    imm6 = {{6{c[12]}}, c[12], c[6:2]};
    joff = {{9{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
    boff = {{4{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};
    w    = '0;
    bad  = 1'b0;
    case ({c[1:0], c[15:13]})
      5'b00_000: begin
        imm = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00};
        w   = {imm, 5'd2, 3'b000, rdp, 7'h13};
        bad = (imm == 12'd0);
      end
      5'b00_010: begin
        imm = {5'd0, c[5], c[12:10], c[6], 2'b00};
        w   = {imm, rs1p, 3'b010, rdp, 7'h03};
      end
      5'b00_100: begin
        if (c[12:10] == 3'b000) begin
          w = {10'd0, c[5], c[6], rs1p, 3'b100, rdp, 7'h03};
        end else if (c[12:10] == 3'b001) begin
          w = {10'd0, c[5], 1'b0, rs1p, (c[6] ? 3'b001 : 3'b101), rdp, 7'h03};
        end else begin
          bad = 1'b1;
        end
      end
      5'b00_110: begin
        imm = {5'd0, c[5], c[12:10], c[6], 2'b00};
        w   = {imm[11:5], rdp, rs1p, 3'b010, imm[4:0], 7'h23};
      end
      5'b01_000: w = {imm6, rd, 3'b000, rd, 7'h13};
      5'b01_001: w = {joff[20], joff[10:1], joff[11], joff[19:12], 5'd1, 7'h6f};
      5'b01_010: w = {imm6, 5'd0, 3'b000, rd, 7'h13};
      5'b01_011: begin
        bad = ({c[12], c[6:2]} == 6'd0);
        if (rd == 5'd2) begin
          w = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000, 5'd2, 3'b000, 5'd2, 7'h13};
        end else begin
          w = {{15{c[12]}}, c[6:2], rd, 7'h37};
        end
      end
      5'b01_100: begin
        case (c[11:10])
          2'b00: w = {7'b0000000, c[6:2], rs1p, 3'b101, rs1p, 7'h13};
          2'b01: w = {7'b0100000, c[6:2], rs1p, 3'b101, rs1p, 7'h13};
          2'b10: w = {imm6, rs1p, 3'b111, rs1p, 7'h13};
          default: begin
            case ({c[12], c[6:5]})
              3'b000: w = {7'b0100000, rdp, rs1p, 3'b000, rs1p, 7'h33};
              3'b001: w = {7'b0000000, rdp, rs1p, 3'b100, rs1p, 7'h33};
              3'b010: w = {7'b0000000, rdp, rs1p, 3'b110, rs1p, 7'h33};
              3'b011: w = {7'b0000000, rdp, rs1p, 3'b111, rs1p, 7'h33};
              3'b110: w = {7'b0000001, rdp, rs1p, 3'b000, rs1p, 7'h33};
              3'b111: begin
                case (c[4:2])
                  3'b000: w = {12'h0ff, rs1p, 3'b111, rs1p, 7'h13};
                  3'b001: w = {12'h604, rs1p, 3'b001, rs1p, 7'h13};
                  3'b010: w = {12'h080, rs1p, 3'b100, rs1p, 7'h33};
                  3'b011: w = {12'h605, rs1p, 3'b001, rs1p, 7'h13};
                  3'b101: w = {12'hfff, rs1p, 3'b100, rs1p, 7'h13};
                  default: bad = 1'b1;
                endcase
              end
              default: bad = 1'b1;
            endcase
          end
        endcase
      end
      5'b01_101: w = {joff[20], joff[10:1], joff[11], joff[19:12], 5'd0, 7'h6f};
      // beqz and bnez differ only in funct3 bit 0
      5'b01_110, 5'b01_111: begin
        w = {boff[12], boff[10:5], 5'd0, rs1p, {2'b00, c[13]}, boff[4:1], boff[11], 7'h63};
      end
      5'b10_000: w = {6'd0, c[12], c[6:2], rd, 3'b001, rd, 7'h13};
      5'b10_010: begin
        w   = {4'd0, c[3:2], c[12], c[6:4], 2'b00, 5'd2, 3'b010, rd, 7'h03};
        bad = (rd == 5'd0);
      end
      5'b10_100: begin
        if (!c[12]) begin
          if (rs2 == 5'd0) begin
            w   = {12'd0, rd, 3'b000, 5'd0, 7'h67};
            bad = (rd == 5'd0);
          end else begin
            w = {7'd0, rs2, 5'd0, 3'b000, rd, 7'h33};
          end
        end else if (rs2 != 5'd0) begin
          w = {7'd0, rs2, rd, 3'b000, rd, 7'h33};
        end else if (rd == 5'd0) begin
          w = 32'h0010_0073;
        end else begin
          w = {12'd0, rd, 3'b000, 5'd1, 7'h67};
        end
      end
      5'b10_110: begin
        imm = {4'd0, c[8:7], c[12:9], 2'b00};
        w   = {imm[11:5], rs2, 5'd2, 3'b010, imm[4:0], 7'h23};
      end
      default: bad = 1'b1;
    endcase
    if (bad) begin
      w = '0;
    end
    return {bad, w};
  endfunction

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic check_instr(input string name, input int lane, input instr_t exp,
                             input instr_t act);
    if (act !== exp) begin
      $display("[FAIL] %s lane %0d word: expected %h, actual %h", name, lane, exp, act);
      $display("** FAIL **");
      $fatal(1, "expanded word mismatch");
    end
  endtask

  task automatic check_illegal(input string name, input int lane, input logic exp,
                               input logic act);
    if (act !== exp) begin
      $display("[FAIL] %s lane %0d illegal: expected %b, actual %b", name, lane, exp, act);
      $display("** FAIL **");
      $fatal(1, "illegal flag mismatch");
    end
  endtask

  task automatic check_valid(input string name, input int lane, input logic exp,
                             input logic act);
    if (act !== exp) begin
      $display("[FAIL] %s lane %0d valid: expected %b, actual %b", name, lane, exp, act);
      $display("** FAIL **");
      $fatal(1, "lane valid mismatch");
    end
  endtask

  task automatic drive_block(input string name, input logic valid,
                             input logic [NUM_LANES-1:0] mask,
                             input parcel_t [NUM_LANES-1:0] blk);
    @(posedge clk);
    fetch_valid <= valid;
    lane_mask   <= mask;
    fetch_block <= blk;
    test_name   <= name;
    sent_lanes  += $countones(mask & {NUM_LANES{valid}});
  endtask

  // inputs and outputs are stable at the falling edge
  // the feeder takes an entry pushed here at the next rising edge
  // and the drainer shows its result one edge after that
  always @(negedge clk) begin
    logic [NUM_LANES-1:0]    v;
    parcel_t [NUM_LANES-1:0] b;
    string                   n;
    logic [32:0]             e;
    if (exp_valid_q.size() == 2) begin
      v = exp_valid_q.pop_front();
      b = exp_block_q.pop_front();
      n = exp_name_q.pop_front();
      for (int l = 0; l < NUM_LANES; l++) begin
        e = ref_expand(b[l]);
        check_valid(n, l, v[l], instr_valid[l]);
        if (v[l]) begin
          check_instr(n, l, e[31:0], instr_block[l]);
          check_illegal(n, l, e[32], illegal[l]);
        end else begin
          check_illegal(n, l, 1'b0, illegal[l]);
        end
      end
      checked_lanes += $countones(v);
    end
    exp_valid_q.push_back(rst ? '0 : (lane_mask & {NUM_LANES{fetch_valid}}));
    exp_block_q.push_back(fetch_block);
    exp_name_q.push_back(test_name);
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("** FAIL **");
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin
    parcel_t [NUM_LANES-1:0] blk;
    logic [31:0]             r;
    rst         = 1'b1;
    fetch_valid = 1'b0;
    fetch_block = '0;
    lane_mask   = '0;
    test_name   = "reset";
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < N_DIRECTED / NUM_LANES; i++) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        blk[l] = directed[i * NUM_LANES + l];
      end
      drive_block($sformatf("directed block %0d", i), 1'b1, '1, blk);
    end

    // back-to-back blocks with every lane live
    for (int i = 0; i < N_RANDOM; i++) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        r = $random(seed);
        blk[l] = r[15:0];
      end
      drive_block("random", 1'b1, '1, blk);
    end

    // idle cycles and cleared mask bits
    for (int i = 0; i < N_MIXED; i++) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        r = $random(seed);
        blk[l] = r[15:0];
      end
      r = $random(seed);
      drive_block("masked", r[31], r[NUM_LANES-1:0], blk);
    end

    // wait out the two-cycle latency so the last compare has run
    drive_block("drain", 1'b0, '0, blk);
    repeat (3) @(posedge clk);
    if (checked_lanes == sent_lanes) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("compared %0d valid lanes but sent %0d", checked_lanes, sent_lanes);
      $display("** FAIL **");
      $fatal(1, "lane count mismatch");
    end
  end

endmodule

//--- project.f
rtl/rv_isa_pkg.sv
rtl/rvc_pkg.sv
rtl/fetch_parcel_split.sv
rtl/rvc_expand_lane.sv
rtl/expand_result_reg.sv
rtl/rvc_expand_top.sv
testbench/rvc_expand_sva.sv
testbench/tb_rvc_expand.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_rvc_expand -f project.f -o tb_rvc_expand &&
./obj_dir/tb_rvc_expand || exit 1
